/* hdl/decay_test_pkg.sv */
// Types, timing constants, fixed test location and data pattern
// shared by the DDR3 retention test controller
package decay_test_pkg;

    localparam int DFI_WORD_W = 32;

    typedef logic [14:0]           dfi_addr_t;
    typedef logic [2:0]            dfi_bank_t;
    typedef logic [DFI_WORD_W-1:0] dfi_word_t;
    typedef logic [3:0]            dfi_mask_t;
    typedef logic [127:0]          burst_data_t;
    typedef logic [27:0]           timer_t;

    // Command codes from sequencer to pin encoder
    typedef enum logic [3:0] {
        DESELECT,
        NOP,
        MRS2,
        MRS3,
        MRS1,
        MRS0,
        ZQCL,
        ACTIVATE,
        WRITE,
        READ,
        PRECHARGE_ALL
    } ddr_cmd_t;

    typedef enum logic [4:0] {
        S_IDLE, S_INIT_RESET, S_INIT_CKE_LOW, S_INIT_STABLE,
        S_INIT_MRS2, S_INIT_MRS3, S_INIT_MRS1, S_INIT_MRS0,
        S_INIT_ZQCL, S_INIT_DONE,
        S_WR_ACTIVATE, S_WR_CMD, S_WR_RECOVER, S_PRECHARGE,
        S_DECAY, S_RD_ACTIVATE, S_RD_CMD, S_DONE
    } seq_state_t;

    // Waits in clk_phy_sys cycles (200 MHz)
    localparam timer_t T_RESET              = 28'd40_000;   // 200 us reset low
    localparam timer_t T_STABLE             = 28'd100_000;  // 500 us CKE low
    localparam timer_t T_INIT_WAIT          = 28'd1024;
    localparam timer_t T_MODE_REG_SET       = 28'd20;       // tMRD with margin
    localparam timer_t T_ZQINIT             = 28'd512;
    localparam timer_t T_ACTIVATE_TO_RW     = 28'd20;       // tRCD with margin
    localparam timer_t T_WRITE_TO_PRECHARGE = 28'd30;       // tWR plus margin
    localparam timer_t T_PRECHARGE          = 28'd20;       // tRP with margin
    localparam timer_t T_DECAY              = 28'd200_000;  // 1 ms retention

    localparam int WL_CYCLES       = 13;  // Write command to first beat, minus one
    localparam int TPHY_RDLAT      = 4;
    localparam int CAS_LATENCY     = 6;
    localparam int BEATS_PER_BURST = 4;   // BL8 on a 16-bit part
    localparam int WL_CNT_W        = $clog2(WL_CYCLES);
    localparam int BEAT_IDX_W      = $clog2(BEATS_PER_BURST);

    localparam dfi_bank_t TEST_BANK = 3'd0;
    localparam dfi_addr_t TEST_ROW  = 15'd0;
    localparam dfi_addr_t TEST_COL  = 15'd0;

    localparam dfi_addr_t MR1_VALUE = 15'h0010;
    // MR0 with BL8, sequential, CL6, DLL reset, WR6
    localparam dfi_addr_t MR0_VALUE = 15'h0520;

    localparam burst_data_t TEST_PATTERN = 128'h1234_5678_9ABC_DEF0_A5A5_5A5A_DEAD_BEEF;

    // PHY and host disagree on halfword order within a beat
    function automatic dfi_word_t swap_halfwords(input dfi_word_t w);
        return {w[15:0], w[31:16]};
    endfunction

endpackage

/* hdl/dfi_cmd_encoder.sv */
// Command code to DFI pin decode
`timescale 1ns/100ps

module dfi_cmd_encoder (
    input  decay_test_pkg::ddr_cmd_t  cmd_i,
    output logic                      dfi_cs_n_o,
    output logic                      dfi_ras_n_o,
    output logic                      dfi_cas_n_o,
    output logic                      dfi_we_n_o,
    output decay_test_pkg::dfi_bank_t dfi_bank_o,
    output decay_test_pkg::dfi_addr_t dfi_address_o
);
    import decay_test_pkg::*;

    logic [2:0] rcw;   // RAS_n, CAS_n, WE_n

    always_comb begin
        rcw           = 3'b111;   // NOP pattern
        dfi_cs_n_o    = 1'b0;
        dfi_bank_o    = '0;
        dfi_address_o = '0;
        case (cmd_i)
            DESELECT: dfi_cs_n_o = 1'b1;
            NOP:      rcw = 3'b111;
            MRS2: begin
                rcw        = 3'b000;
                dfi_bank_o = 3'd2;
            end
            MRS3: begin
                rcw        = 3'b000;
                dfi_bank_o = 3'd3;
            end
            MRS1: begin
                rcw           = 3'b000;
                dfi_bank_o    = 3'd1;
                dfi_address_o = MR1_VALUE;
            end
            MRS0: begin
                rcw           = 3'b000;
                dfi_address_o = MR0_VALUE;
            end
            ZQCL: begin
                rcw               = 3'b110;
                dfi_address_o[10] = 1'b1;   // Long calibration
            end
            ACTIVATE: begin
                rcw           = 3'b011;
                dfi_bank_o    = TEST_BANK;
                dfi_address_o = TEST_ROW;
            end
            WRITE: begin
                rcw           = 3'b100;
                dfi_bank_o    = TEST_BANK;
                dfi_address_o = TEST_COL;
            end
            READ: begin
                rcw           = 3'b101;
                dfi_bank_o    = TEST_BANK;
                dfi_address_o = TEST_COL;
            end
            PRECHARGE_ALL: begin
                rcw               = 3'b010;
                dfi_address_o[10] = 1'b1;   // All banks
            end
            default: dfi_cs_n_o = 1'b1;
        endcase
    end

    assign {dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} = rcw;

    // Chip stays selected for every real command
    always_comb begin
        assert final (dfi_cs_n_o == (cmd_i == DESELECT));
    end

endmodule

/* hdl/wrdata_burst.sv */
// Write latency wait and four-beat write burst with ODT
`timescale 1ns/100ps

module wrdata_burst (
    input  logic                      clk_phy_sys,
    input  logic                      sys_rst_fsm_phy,
    input  logic                      wr_start_i,
    output decay_test_pkg::dfi_word_t dfi_wrdata_o,
    output logic                      dfi_wrdata_en_o,
    output decay_test_pkg::dfi_mask_t dfi_wrdata_mask_o,
    output logic                      dfi_odt_o,
    output logic                      wr_done_o
);
    import decay_test_pkg::*;

    logic                  lat_run_q;
    logic [WL_CNT_W-1:0]   lat_cnt_q;
    logic                  burst_q;
    logic [BEAT_IDX_W-1:0] beat_q;
    logic                  last_beat;

    assign last_beat = burst_q && (beat_q == BEAT_IDX_W'(BEATS_PER_BURST - 1));

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            lat_run_q <= 1'b0;
            lat_cnt_q <= '0;
            burst_q   <= 1'b0;
            beat_q    <= '0;
        end else begin
            if (wr_start_i) begin
                lat_run_q <= 1'b1;
                lat_cnt_q <= '0;
            end else if (lat_run_q) begin
                lat_cnt_q <= lat_cnt_q + 1'b1;
                if (lat_cnt_q == WL_CNT_W'(WL_CYCLES - 1)) begin   // First beat next cycle
                    lat_run_q <= 1'b0;
                    burst_q   <= 1'b1;
                    beat_q    <= '0;
                end
            end
            if (last_beat) begin
                burst_q <= 1'b0;
            end else if (burst_q) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Low word goes first
    assign dfi_wrdata_o = burst_q ?
        swap_halfwords(TEST_PATTERN[beat_q*DFI_WORD_W +: DFI_WORD_W]) : '0;
    assign dfi_wrdata_en_o   = burst_q;
    assign dfi_odt_o         = burst_q;
    assign dfi_wrdata_mask_o = '0;      // All bytes written
    assign wr_done_o         = last_beat;

    assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        dfi_wrdata_en_o [*BEATS_PER_BURST] |=> !dfi_wrdata_en_o);

endmodule

/* hdl/rddata_capture.sv */
// Read burst capture, halfword unswap and pattern compare
`timescale 1ns/100ps

module rddata_capture (
    input  logic                      clk_phy_sys,
    input  logic                      sys_rst_fsm_phy,
    input  logic                      rd_start_i,
    input  decay_test_pkg::dfi_word_t dfi_rddata_i,
    input  logic                      dfi_rddata_valid_i,
    output logic                      dfi_rddata_en_o,
    output logic                      data_match_o,
    output logic                      rd_done_o
);
    import decay_test_pkg::*;

    logic                  active_q;
    logic [BEAT_IDX_W-1:0] beat_q;
    burst_data_t           capture_q;
    burst_data_t           capture_nxt;
    logic                  beat_in;
    logic                  last_beat;
    logic                  match_q;
    logic                  done_q;

    assign beat_in   = active_q && dfi_rddata_valid_i;
    assign last_beat = beat_in && (beat_q == BEAT_IDX_W'(BEATS_PER_BURST - 1));

    // Incoming beat dropped into its slot
    always_comb begin
        capture_nxt = capture_q;
        capture_nxt[beat_q*DFI_WORD_W +: DFI_WORD_W] = swap_halfwords(dfi_rddata_i);
    end

    always_ff @(posedge clk_phy_sys) begin
        if (rd_start_i) begin
            capture_q <= '0;
        end else if (beat_in) begin
            capture_q <= capture_nxt;
        end
    end

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            active_q <= 1'b0;
            beat_q   <= '0;
            match_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_beat;
            if (rd_start_i) begin
                active_q <= 1'b1;
                beat_q   <= '0;
                match_q  <= 1'b0;
            end else if (beat_in) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    active_q <= 1'b0;
                    match_q  <= (capture_nxt == TEST_PATTERN);   // Full burst compare
                end
            end
        end
    end

    assign dfi_rddata_en_o = rd_start_i | active_q;   // Up in the READ cycle
    assign data_match_o    = match_q;
    assign rd_done_o       = done_q;

    // PHY must not return data that was never requested
    assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        dfi_rddata_valid_i |-> dfi_rddata_en_o);

endmodule

/* hdl/decay_test_sequencer.sv */
// Test sequence FSM with wait timer, start edge detect
// and status LED decode
`timescale 1ns/100ps

module decay_test_sequencer (
    input  logic                       clk_phy_sys,
    input  logic                       sys_rst_fsm_phy,
    input  logic                       start_btn_i,
    input  logic                       wr_done_i,
    input  logic                       rd_done_i,
    input  logic                       data_match_i,
    output decay_test_pkg::ddr_cmd_t   cmd_o,
    output logic                       wr_start_o,
    output logic                       rd_start_o,
    output logic                       dfi_cke_o,
    output logic                       dfi_reset_n_o,
    output logic                       status_busy_led_o,
    output logic                       status_pass_led_o,
    output logic                       status_fail_led_o
);
    import decay_test_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    timer_t     timer_q;
    logic       entry_q;     // First cycle in current state
    logic       start_q;
    logic       start_edge;

    assign start_edge = start_btn_i & ~start_q;

    always_ff @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            state_q <= S_IDLE;
            timer_q <= '0;
            entry_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            entry_q <= (state_d != state_q);
            start_q <= start_btn_i;
            if (state_d != state_q) begin
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + 1'b1;
            end
        end
    end

    // Next state, each timed state lasts its wait plus the entry cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE:         if (start_edge) state_d = S_INIT_RESET;
            S_INIT_RESET:   if (timer_q >= T_RESET) state_d = S_INIT_CKE_LOW;
            S_INIT_CKE_LOW: if (timer_q >= T_STABLE) state_d = S_INIT_STABLE;
            S_INIT_STABLE:  if (timer_q >= T_INIT_WAIT) state_d = S_INIT_MRS2;
            S_INIT_MRS2:    if (timer_q >= T_MODE_REG_SET) state_d = S_INIT_MRS3;
            S_INIT_MRS3:    if (timer_q >= T_MODE_REG_SET) state_d = S_INIT_MRS1;
            S_INIT_MRS1:    if (timer_q >= T_MODE_REG_SET) state_d = S_INIT_MRS0;
            S_INIT_MRS0:    if (timer_q >= T_MODE_REG_SET) state_d = S_INIT_ZQCL;
            S_INIT_ZQCL:    if (timer_q >= T_ZQINIT) state_d = S_INIT_DONE;
            S_INIT_DONE:    if (timer_q >= T_INIT_WAIT) state_d = S_WR_ACTIVATE;
            S_WR_ACTIVATE:  if (timer_q >= T_ACTIVATE_TO_RW) state_d = S_WR_CMD;
            S_WR_CMD:       if (wr_done_i) state_d = S_WR_RECOVER;   // Last beat out
            S_WR_RECOVER:   if (timer_q >= T_WRITE_TO_PRECHARGE) state_d = S_PRECHARGE;
            S_PRECHARGE:    if (timer_q >= T_PRECHARGE) state_d = S_DECAY;
            S_DECAY:        if (timer_q >= T_DECAY) state_d = S_RD_ACTIVATE;
            S_RD_ACTIVATE:  if (timer_q >= T_ACTIVATE_TO_RW) state_d = S_RD_CMD;
            S_RD_CMD:       if (rd_done_i) state_d = S_DONE;
            S_DONE:         if (start_edge) state_d = S_IDLE;
            default:        state_d = S_IDLE;
        endcase
    end

    // Commands go out for one cycle on entry, NOP for the rest of the wait
    always_comb begin
        cmd_o = NOP;
        case (state_q)
            S_IDLE, S_INIT_RESET, S_INIT_CKE_LOW: cmd_o = DESELECT;
            S_INIT_MRS2: if (entry_q) cmd_o = MRS2;
            S_INIT_MRS3: if (entry_q) cmd_o = MRS3;
            S_INIT_MRS1: if (entry_q) cmd_o = MRS1;
            S_INIT_MRS0: if (entry_q) cmd_o = MRS0;
            S_INIT_ZQCL: if (entry_q) cmd_o = ZQCL;
            S_WR_ACTIVATE, S_RD_ACTIVATE: begin
                if (entry_q) cmd_o = ACTIVATE;
            end
            S_WR_CMD:    if (entry_q) cmd_o = WRITE;
            S_PRECHARGE: if (entry_q) cmd_o = PRECHARGE_ALL;
            S_RD_CMD:    if (entry_q) cmd_o = READ;
            default:     cmd_o = NOP;
        endcase
    end

    assign wr_start_o = entry_q && (state_q == S_WR_CMD);   // Same cycle as WRITE
    assign rd_start_o = entry_q && (state_q == S_RD_CMD);

    // Power-up levels
    assign dfi_reset_n_o = (state_q != S_INIT_RESET);
    assign dfi_cke_o     = !(state_q inside {S_IDLE, S_INIT_RESET, S_INIT_CKE_LOW});

    assign status_busy_led_o = (state_q != S_IDLE) && (state_q != S_DONE);
    assign status_pass_led_o = (state_q == S_DONE) && data_match_i;
    assign status_fail_led_o = (state_q == S_DONE) && !data_match_i;

    // Write and read phases never overlap
    assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        !(wr_start_o && rd_start_o));

    // Result holds until the operator presses start again
    assert property (@(posedge clk_phy_sys) disable iff (sys_rst_fsm_phy)
        (state_q == S_DONE && !start_edge) |=> (state_q == S_DONE));

endmodule

/* hdl/decay_test_top.sv */
// Retention test controller top
// Sequencer, command encoder, write burst and read capture
`timescale 1ns/100ps

module decay_test_top (
    input  logic                        clk_phy_sys,
    input  logic                        sys_rst_fsm_phy,
    input  logic                        start_btn_i,   // Already synchronous

    // DFI command side
    output logic                        dfi_cke_o,
    output logic                        dfi_reset_n_o,
    output logic                        dfi_cs_n_o,
    output logic                        dfi_ras_n_o,
    output logic                        dfi_cas_n_o,
    output logic                        dfi_we_n_o,
    output decay_test_pkg::dfi_bank_t   dfi_bank_o,
    output decay_test_pkg::dfi_addr_t   dfi_address_o,
    output logic                        dfi_odt_o,

    // DFI data side
    output decay_test_pkg::dfi_word_t   dfi_wrdata_o,
    output logic                        dfi_wrdata_en_o,
    output decay_test_pkg::dfi_mask_t   dfi_wrdata_mask_o,
    output logic                        dfi_rddata_en_o,
    input  decay_test_pkg::dfi_word_t   dfi_rddata_i,
    input  logic                        dfi_rddata_valid_i,

    output logic                        status_busy_led_o,
    output logic                        status_pass_led_o,
    output logic                        status_fail_led_o
);
    import decay_test_pkg::*;

    ddr_cmd_t cmd;
    logic     wr_start;
    logic     wr_done;
    logic     rd_start;
    logic     rd_done;
    logic     data_match;

    decay_test_sequencer u_sequencer (
        .clk_phy_sys       (clk_phy_sys),
        .sys_rst_fsm_phy   (sys_rst_fsm_phy),
        .start_btn_i       (start_btn_i),
        .wr_done_i         (wr_done),
        .rd_done_i         (rd_done),
        .data_match_i      (data_match),
        .cmd_o             (cmd),
        .wr_start_o        (wr_start),
        .rd_start_o        (rd_start),
        .dfi_cke_o         (dfi_cke_o),
        .dfi_reset_n_o     (dfi_reset_n_o),
        .status_busy_led_o (status_busy_led_o),
        .status_pass_led_o (status_pass_led_o),
        .status_fail_led_o (status_fail_led_o)
    );

    dfi_cmd_encoder u_cmd_encoder (
        .cmd_i         (cmd),
        .dfi_cs_n_o    (dfi_cs_n_o),
        .dfi_ras_n_o   (dfi_ras_n_o),
        .dfi_cas_n_o   (dfi_cas_n_o),
        .dfi_we_n_o    (dfi_we_n_o),
        .dfi_bank_o    (dfi_bank_o),
        .dfi_address_o (dfi_address_o)
    );

    wrdata_burst u_wrdata_burst (
        .clk_phy_sys       (clk_phy_sys),
        .sys_rst_fsm_phy   (sys_rst_fsm_phy),
        .wr_start_i        (wr_start),
        .dfi_wrdata_o      (dfi_wrdata_o),
        .dfi_wrdata_en_o   (dfi_wrdata_en_o),
        .dfi_wrdata_mask_o (dfi_wrdata_mask_o),
        .dfi_odt_o         (dfi_odt_o),
        .wr_done_o         (wr_done)
    );

    rddata_capture u_rddata_capture (
        .clk_phy_sys        (clk_phy_sys),
        .sys_rst_fsm_phy    (sys_rst_fsm_phy),
        .rd_start_i         (rd_start),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .dfi_rddata_en_o    (dfi_rddata_en_o),
        .data_match_o       (data_match),
        .rd_done_o          (rd_done)
    );

endmodule

/* dv/dfi_mem_model.sv */
// DFI PHY and one-burst memory model for the testbench
// with an optional single bit flip to mimic retention loss
`timescale 1ns/100ps

module dfi_mem_model (
    input  logic                      clk_phy_sys,
    input  logic                      sys_rst_fsm_phy,
    input  logic                      dfi_cs_n_i,
    input  logic                      dfi_ras_n_i,
    input  logic                      dfi_cas_n_i,
    input  logic                      dfi_we_n_i,
    input  decay_test_pkg::dfi_word_t dfi_wrdata_i,
    input  logic                      dfi_wrdata_en_i,
    input  logic                      flip_req_i,
    output decay_test_pkg::dfi_word_t dfi_rddata_o,
    output logic                      dfi_rddata_valid_o
);
    import decay_test_pkg::*;

    localparam int RD_LAT = TPHY_RDLAT + CAS_LATENCY;

    dfi_word_t mem [BEATS_PER_BURST];   // Beats kept in DFI order
    int        wr_idx;
    int        rd_wait;
    int        rd_idx;
    int        flip_bit;
    integer    seed = 32'hc4655068;
    logic      write_cmd;
    logic      read_cmd;

    assign write_cmd = !dfi_cs_n_i && ({dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i} == 3'b100);
    assign read_cmd  = !dfi_cs_n_i && ({dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i} == 3'b101);

    always @(posedge clk_phy_sys or posedge sys_rst_fsm_phy) begin
        if (sys_rst_fsm_phy) begin
            for (int i = 0; i < BEATS_PER_BURST; i++) begin
                mem[i] <= 32'h0BAD_0000 | i;
            end
            wr_idx             <= 0;
            rd_wait            <= 0;
            rd_idx             <= BEATS_PER_BURST;   // No read in flight
            dfi_rddata_o       <= '0;
            dfi_rddata_valid_o <= 1'b0;
        end else begin
            if (write_cmd) begin
                wr_idx <= 0;
            end else if (dfi_wrdata_en_i && wr_idx < BEATS_PER_BURST) begin
                mem[wr_idx] <= dfi_wrdata_i;
                wr_idx      <= wr_idx + 1;
            end

            // Single bit upset somewhere in the stored burst
            if (flip_req_i) begin
                flip_bit = $unsigned($random(seed)) % (BEATS_PER_BURST * DFI_WORD_W);
                mem[flip_bit / DFI_WORD_W][flip_bit % DFI_WORD_W] <=
                    ~mem[flip_bit / DFI_WORD_W][flip_bit % DFI_WORD_W];
                $display("memory model: flipped stored bit %0d", flip_bit);
            end

            dfi_rddata_valid_o <= 1'b0;
            if (rd_idx < BEATS_PER_BURST) begin
                dfi_rddata_o       <= mem[rd_idx];
                dfi_rddata_valid_o <= 1'b1;
                rd_idx             <= rd_idx + 1;
            end
            if (read_cmd) begin
                rd_wait <= RD_LAT - 2;   // Index and output stages take two
            end else if (rd_wait > 0) begin
                rd_wait <= rd_wait - 1;
                if (rd_wait == 1) begin
                    rd_idx <= 0;   // First beat RD_LAT cycles after READ
                end
            end
        end
    end

endmodule

/* dv/tb_decay_test.sv */
// Testbench for the retention test controller
// Clock, reset, start stimulus, reference beats, command and data checks
`timescale 1ns/100ps

module tb_decay_test;
    import decay_test_pkg::*;

    // One run of all timed waits, plus slack for bursts and state entries
    localparam int RUN_CYCLES = int'(T_RESET) + int'(T_STABLE) + 2 * int'(T_INIT_WAIT)
        + 4 * int'(T_MODE_REG_SET) + int'(T_ZQINIT) + 2 * int'(T_ACTIVATE_TO_RW)
        + int'(T_WRITE_TO_PRECHARGE) + int'(T_PRECHARGE) + int'(T_DECAY) + 100;
    localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES + 10_000;
    localparam int NUM_STEPS      = 12;

    logic        clk_phy_sys = 1'b0;
    logic        sys_rst_fsm_phy;
    logic        start_btn;
    logic        flip_req;
    logic        dfi_cke, dfi_reset_n, dfi_odt;
    logic        dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n;
    dfi_bank_t   dfi_bank;
    dfi_addr_t   dfi_address;
    dfi_word_t   dfi_wrdata, dfi_rddata;
    dfi_mask_t   dfi_wrdata_mask;
    logic        dfi_wrdata_en, dfi_rddata_en, dfi_rddata_valid;
    logic        busy_led, pass_led, fail_led;

    int          cycle_cnt     = 0;
    int          check_cnt     = 0;
    int          error_cnt     = 0;
    int          test_cnt      = 0;
    int          test_err_base = 0;
    int          seq_idx       = 0;   // Next expected step in the run
    int          wr_beats      = 0;
    int          wr_cmd_cycle  = 0;
    logic        burst_seen    = 1'b0;
    logic        reset_n_prev  = 1'b1;
    logic        cke_prev      = 1'b0;
    logic        wr_en_prev    = 1'b0;
    string       cmd_name;

    always #5 clk_phy_sys = ~clk_phy_sys;

    decay_test_top decay_test_top_i (
        .clk_phy_sys        (clk_phy_sys),
        .sys_rst_fsm_phy    (sys_rst_fsm_phy),
        .start_btn_i        (start_btn),
        .dfi_cke_o          (dfi_cke),
        .dfi_reset_n_o      (dfi_reset_n),
        .dfi_cs_n_o         (dfi_cs_n),
        .dfi_ras_n_o        (dfi_ras_n),
        .dfi_cas_n_o        (dfi_cas_n),
        .dfi_we_n_o         (dfi_we_n),
        .dfi_bank_o         (dfi_bank),
        .dfi_address_o      (dfi_address),
        .dfi_odt_o          (dfi_odt),
        .dfi_wrdata_o       (dfi_wrdata),
        .dfi_wrdata_en_o    (dfi_wrdata_en),
        .dfi_wrdata_mask_o  (dfi_wrdata_mask),
        .dfi_rddata_en_o    (dfi_rddata_en),
        .dfi_rddata_i       (dfi_rddata),
        .dfi_rddata_valid_i (dfi_rddata_valid),
        .status_busy_led_o  (busy_led),
        .status_pass_led_o  (pass_led),
        .status_fail_led_o  (fail_led)
    );

    dfi_mem_model u_mem_model (
        .clk_phy_sys        (clk_phy_sys),
        .sys_rst_fsm_phy    (sys_rst_fsm_phy),
        .dfi_cs_n_i         (dfi_cs_n),
        .dfi_ras_n_i        (dfi_ras_n),
        .dfi_cas_n_i        (dfi_cas_n),
        .dfi_we_n_i         (dfi_we_n),
        .dfi_wrdata_i       (dfi_wrdata),
        .dfi_wrdata_en_i    (dfi_wrdata_en),
        .flip_req_i         (flip_req),
        .dfi_rddata_o       (dfi_rddata),
        .dfi_rddata_valid_o (dfi_rddata_valid)
    );

    // Host word n of the pattern, halfwords swapped into PHY order
    function automatic dfi_word_t expected_beat(input int n);
        dfi_word_t host_word;
        host_word = TEST_PATTERN[n*32 +: 32];
        return {host_word[15:0], host_word[31:16]};
    endfunction

    function automatic bit expected_pass(input bit bit_flipped);
        return !bit_flipped;
    endfunction

    function automatic string step_name(input int idx);
        case (idx)
            0:       return "RESET_LOW";
            1:       return "CKE_HIGH";
            2:       return "MRS2";
            3:       return "MRS3";
            4:       return "MRS1";
            5:       return "MRS0";
            6:       return "ZQCL";
            7:       return "ACTIVATE";
            8:       return "WRITE";
            9:       return "PRECHARGE";
            10:      return "ACTIVATE";
            11:      return "READ";
            default: return "END";
        endcase
    endfunction

    // DDR3 truth table with chip selected
    function automatic string decode_pins(input logic [2:0] rcw, input dfi_bank_t bank);
        case (rcw)
            3'b000:  return $sformatf("MRS%0d", bank);
            3'b011:  return "ACTIVATE";
            3'b100:  return "WRITE";
            3'b101:  return "READ";
            3'b010:  return "PRECHARGE";
            3'b110:  return "ZQCL";
            3'b111:  return "NOP";
            default: return "REFRESH";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic record_step(input string name);
        check_cnt++;
        assert (name == step_name(seq_idx)) else begin
            $display("command step %0d was %s where %s should come", seq_idx, name,
                     step_name(seq_idx));
            error_cnt++;
        end
        seq_idx++;
    endtask

    task automatic inspect_command(input string name);
        if (name == "MRS0") begin
            compare_value("dfi_address_o", dfi_address, MR0_VALUE);
        end else if (name == "MRS1") begin
            compare_value("dfi_address_o", dfi_address, MR1_VALUE);
        end else if (name == "ZQCL" || name == "PRECHARGE") begin
            compare_value("dfi_address_o[10]", dfi_address[10], 1);
        end else if (name == "ACTIVATE") begin
            compare_value("dfi_bank_o", dfi_bank, TEST_BANK);
            compare_value("dfi_address_o", dfi_address, TEST_ROW);
        end else if (name == "WRITE" || name == "READ") begin
            compare_value("dfi_bank_o", dfi_bank, TEST_BANK);
            compare_value("dfi_address_o", dfi_address, TEST_COL);
            compare_value("dfi_rddata_en_o", dfi_rddata_en, name == "READ");
            wr_cmd_cycle = cycle_cnt;
            wr_beats     = 0;
        end
    endtask

    task automatic expect_idle_outputs();
        compare_value("status_busy_led_o", busy_led, 0);
        compare_value("status_pass_led_o", pass_led, 0);
        compare_value("status_fail_led_o", fail_led, 0);
        compare_value("dfi_wrdata_en_o", dfi_wrdata_en, 0);
        compare_value("dfi_rddata_en_o", dfi_rddata_en, 0);
        compare_value("dfi_odt_o", dfi_odt, 0);
        compare_value("dfi_cke_o", dfi_cke, 0);
        compare_value("dfi_cs_n_o", dfi_cs_n, 1);
        compare_value("dfi_reset_n_o", dfi_reset_n, 1);
    endtask

    // One-cycle button pulse, returns in the cycle the DUT reacts
    task automatic press_start();
        @(posedge clk_phy_sys);
        start_btn <= 1'b1;
        @(posedge clk_phy_sys);
        start_btn <= 1'b0;
        @(negedge clk_phy_sys);
    endtask

    task automatic wait_for_result(input bit exp_pass);
        @(negedge clk_phy_sys);
        while (!(pass_led || fail_led)) begin
            @(negedge clk_phy_sys);
        end
        compare_value("status_pass_led_o", pass_led, exp_pass);
        compare_value("status_fail_led_o", fail_led, !exp_pass);
        compare_value("status_busy_led_o", busy_led, 0);
        compare_value("command steps seen", seq_idx, NUM_STEPS);
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        if (error_cnt == test_err_base) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_err_base);
        end
        test_err_base = error_cnt;
    endtask

    // Bus monitor, sampled mid-cycle
    always @(negedge clk_phy_sys) begin
        if (!sys_rst_fsm_phy) begin
            if (reset_n_prev && !dfi_reset_n) begin   // New run
                seq_idx    = 0;
                burst_seen = 1'b0;
                record_step("RESET_LOW");
            end
            if (!cke_prev && dfi_cke) begin
                record_step("CKE_HIGH");
            end
            if (!dfi_cs_n) begin
                cmd_name = decode_pins({dfi_ras_n, dfi_cas_n, dfi_we_n}, dfi_bank);
                if (cmd_name != "NOP") begin
                    record_step(cmd_name);
                    inspect_command(cmd_name);
                end
            end
            if (dfi_wrdata_en) begin
                if (wr_beats == 0) begin
                    compare_value("first beat delay", cycle_cnt - wr_cmd_cycle, WL_CYCLES + 1);
                end
                compare_value("dfi_wrdata_o", dfi_wrdata,
                              expected_beat(wr_beats % BEATS_PER_BURST));
                compare_value("dfi_wrdata_mask_o", dfi_wrdata_mask, 0);
                compare_value("dfi_odt_o", dfi_odt, 1);
                wr_beats++;
            end else begin
                if (wr_en_prev) begin
                    compare_value("write beat count", wr_beats, BEATS_PER_BURST);
                    burst_seen = 1'b1;
                end
                if (dfi_odt) begin
                    compare_value("dfi_odt_o", dfi_odt, 0);   // ODT outside the burst
                end
            end
            wr_en_prev = dfi_wrdata_en;
        end
        reset_n_prev = dfi_reset_n;
        cke_prev     = dfi_cke;
    end

    always @(posedge clk_phy_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        sys_rst_fsm_phy = 1'b1;
        start_btn       = 1'b0;
        flip_req        = 1'b0;

        repeat (2) @(posedge clk_phy_sys);
        @(negedge clk_phy_sys);
        expect_idle_outputs();
        repeat (3) @(posedge clk_phy_sys);
        sys_rst_fsm_phy <= 1'b0;
        @(negedge clk_phy_sys);
        expect_idle_outputs();
        report_test("reset values");

        press_start();
        compare_value("dfi_reset_n_o", dfi_reset_n, 0);
        compare_value("status_busy_led_o", busy_led, 1);
        @(posedge clk_phy_sys);
        while (seq_idx < 9) begin
            @(posedge clk_phy_sys);
        end
        report_test("power-up and command order");

        while (!burst_seen) begin
            @(posedge clk_phy_sys);
        end
        report_test("write burst");

        wait_for_result(expected_pass(1'b0));
        report_test("clean run passes");

        press_start();
        expect_idle_outputs();
        report_test("start in done returns to idle");

        // Second run, upset one stored bit during the decay wait
        press_start();
        compare_value("dfi_reset_n_o", dfi_reset_n, 0);
        @(posedge clk_phy_sys);
        while (seq_idx < 10) begin
            @(posedge clk_phy_sys);
        end
        flip_req <= 1'b1;
        @(posedge clk_phy_sys);
        flip_req <= 1'b0;
        wait_for_result(expected_pass(1'b1));
        report_test("rerun with flipped bit fails");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/decay_test_pkg.sv
hdl/dfi_cmd_encoder.sv
hdl/wrdata_burst.sv
hdl/rddata_capture.sv
hdl/decay_test_sequencer.sv
hdl/decay_test_top.sv
dv/dfi_mem_model.sv
dv/tb_decay_test.sv
